// ==== dv/mem_sched_tb.sv ====
// mem_sched_tb runs the memory access scheduler through directed tests and a random run
`timescale 1ns/10ps
`include "sched_defines.svh"

module mem_sched_tb;

    localparam int CLK_NS      = 4;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 1000;             // budget per test for the watchdog
    localparam int GRANT_WAIT  = 40;               // cycles an open window may wait
    localparam int RAND_CYCLES = 600;

    logic                      rst;                // clock
    logic                      clk;                // reset, active high
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    sched_bus_pkg::wb_adr_t    wb_adr;
    sched_bus_pkg::wb_dat_t    wb_dat_w;
    sched_bus_pkg::wb_dat_t    wb_dat_r;
    logic                      wb_ack;
    sched_chan_pkg::chn_mask_t want_rq;
    sched_chan_pkg::chn_mask_t need_rq;
    logic                      en_schedul;
    logic                      grant;
    sched_chan_pkg::chn_idx_t  grant_chn;
    logic                      grant_need;
    int                        err_cnt;            // from the checker
    int                        chk_cnt;
    int                        tb_errs;            // failures seen by the test sequence
    int                        errs_before;        // total at the start of the current test
    int                        test_num;
    logic [31:0]               rng;                // xorshift state
    sched_chan_pkg::chn_idx_t  win_chn;            // last channel granted by open_window
    logic                      win_got;

    mem_sched_top dut_i (.*);
    sched_checker checker_i (.*);

    initial begin
        rst = 1'b0;
        forever #(CLK_NS/2) rst = ~rst;
    end

    // runs only if the test sequence hangs
    initial begin
        #((NUM_TESTS*TEST_CYCLES + 500) * CLK_NS);
        $display("timeout, tests did not finish within %0d cycles", NUM_TESTS*TEST_CYCLES + 500);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic sched_chan_pkg::chn_mask_t bit_of(input int idx);
        return sched_chan_pkg::chn_mask_t'(1) << idx;
    endfunction

    // master holds the strobe until the ack is seen
    task automatic bus_cycle(input logic we, input int adr, input sched_bus_pkg::wb_dat_t dat);
        int n;
        @(posedge rst);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= sched_bus_pkg::wb_adr_t'(adr);
        wb_dat_w <= dat;
        n = 0;
        @(posedge rst);
        while (!wb_ack && n < 8) begin
            @(posedge rst);
            n++;
        end
        if (!wb_ack) begin
            $display("wishbone access to address %0d got no ack", adr);
            tb_errs++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input int adr, input sched_bus_pkg::wb_dat_t dat);
        bus_cycle(1'b1, adr, dat);
    endtask

    task automatic read_reg(input int adr);
        bus_cycle(1'b0, adr, '0);                  // data is compared by the checker
    endtask

    task automatic open_window();
        int n;
        @(posedge rst);
        en_schedul <= 1'b1;
        n       = 0;
        win_got = 1'b0;
        while (!win_got && n < GRANT_WAIT) begin
            @(posedge rst);
            n++;
            if (grant) begin
                win_got = 1'b1;
                win_chn = grant_chn;               // latched with the pulse
            end
        end
        en_schedul <= 1'b0;
        if (!win_got) begin
            $display("no grant within %0d cycles of opening a window", GRANT_WAIT);
            tb_errs++;
        end
    endtask

    // a served channel drops both of its requests
    task automatic serve_one();
        open_window();
        if (win_got) begin
            want_rq <= want_rq & ~bit_of(win_chn);
            need_rq <= need_rq & ~bit_of(win_chn);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        @(negedge rst);                            // counters settled between edges
        errs = tb_errs + err_cnt - errs_before;
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errs);
        errs_before = tb_errs + err_cnt;
    endtask

    task automatic register_access();
        for (int a = 0; a < `SCHED_CHN; a++) begin
            rng = xorshift(rng);
            write_reg(a, rng[15:0]);
        end
        rng = xorshift(rng);
        write_reg(`SCHED_REG_EN, rng[15:0]);
        write_reg(20, 16'hbeef);                   // unmapped address drops the write
        for (int a = 0; a < 32; a++) begin
            read_reg(a);
        end
        write_reg(`SCHED_REG_EN, 16'hffff);
    endtask

    task automatic single_request();
        int n;
        logic got;
        @(posedge rst);
        want_rq    <= bit_of(5);
        en_schedul <= 1'b1;
        n   = 0;
        got = 1'b0;
        while (!got && n < GRANT_WAIT) begin
            @(posedge rst);
            n++;
            got = grant;
        end
        // rises on the second edge, seen as the old value on the third
        if (n != 3 || !got) begin
            $display("single request: grant seen %0d edges after the request, expected 3", n);
            tb_errs++;
        end
        want_rq    <= '0;
        en_schedul <= 1'b0;
    endtask

    task automatic need_beats_want();
        write_reg(2, 16'd200);
        write_reg(3, 16'd10);
        write_reg(7, 16'd50);
        write_reg(9, 16'd51);
        @(posedge rst);
        want_rq <= bit_of(2) | bit_of(7) | bit_of(9);
        need_rq <= bit_of(3);                      // lowest priority yet first
        repeat (4) @(posedge rst);
        serve_one();
        serve_one();                               // 2 on priority
        serve_one();                               // 7 ages up to 9 and takes the tie
        serve_one();
        write_reg(11, 16'hff);
        write_reg(12, 16'hff);
        write_reg(13, 16'hfe);
        @(posedge rst);
        want_rq <= bit_of(13) | bit_of(12) | bit_of(11);
        repeat (6) @(posedge rst);                 // all saturated so the lowest index wins
        serve_one();
        want_rq <= '0;
    endtask

    task automatic enable_masking();
        write_reg(`SCHED_REG_EN, ~(bit_of(4) | bit_of(5)));
        write_reg(4, 16'hf0);
        write_reg(5, 16'hf0);
        write_reg(6, 16'h01);
        @(posedge rst);
        want_rq <= bit_of(4) | bit_of(5) | bit_of(6);
        need_rq <= bit_of(5);                      // disabled need must not win
        repeat (4) @(posedge rst);
        serve_one();
        if (win_got && (win_chn == 4 || win_chn == 5)) begin
            $display("disabled channel %0d was granted", win_chn);
            tb_errs++;
        end
        want_rq <= '0;
        need_rq <= '0;
        write_reg(`SCHED_REG_EN, 16'hffff);
        write_reg(8, 16'hf0);
        write_reg(9, 16'h01);
        @(posedge rst);
        want_rq <= bit_of(8) | bit_of(9);
        repeat (4) @(posedge rst);
        write_reg(`SCHED_REG_EN, ~bit_of(8));      // 8 already confirmed
        repeat (2) @(posedge rst);
        serve_one();
        if (win_got && win_chn == 8) begin
            $display("channel 8 was granted after it was disabled");
            tb_errs++;
        end
        want_rq <= '0;
        write_reg(`SCHED_REG_EN, 16'hffff);
    endtask

    task automatic window_limit();
        int seen;
        @(posedge rst);
        want_rq <= bit_of(1) | bit_of(2) | bit_of(3);
        repeat (4) @(posedge rst);
        for (int w = 0; w < 2; w++) begin
            en_schedul <= 1'b1;
            seen = 0;
            repeat (20) begin
                @(posedge rst);
                seen += grant;
            end
            if (seen != 1) begin
                $display("window %0d held open gave %0d grants, expected 1", w, seen);
                tb_errs++;
            end
            en_schedul <= 1'b0;                    // low for one cycle
            @(posedge rst);
        end
        want_rq <= '0;
    endtask

    task automatic random_traffic();
        sched_chan_pkg::chn_mask_t w;
        sched_chan_pkg::chn_mask_t n;
        int grants;
        grants = 0;
        for (int a = 0; a < `SCHED_CHN; a++) begin
            rng = xorshift(rng);
            write_reg(a, rng[15:0]);
        end
        for (int c = 0; c < RAND_CYCLES; c++) begin
            @(posedge rst);
            w = want_rq;
            n = need_rq;
            if (grant) begin
                grants++;
                w &= ~bit_of(grant_chn);
                n &= ~bit_of(grant_chn);
            end
            rng = xorshift(rng);
            if (rng[0]) w |= bit_of(rng[7:4]);                 // new want in half the cycles
            if (rng[3:1] == 3'd0) n |= bit_of(rng[11:8]);      // rarer need
            if (rng[15:12] == 4'd0) w &= ~bit_of(rng[19:16]);  // withdrawn want
            want_rq    <= w;
            need_rq    <= n;
            en_schedul <= |rng[21:20];
        end
        want_rq    <= '0;
        need_rq    <= '0;
        en_schedul <= 1'b0;
        if (grants == 0) begin
            $display("random run produced no grants");
            tb_errs++;
        end
    endtask

    initial begin
        clk         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        want_rq     = '0;
        need_rq     = '0;
        en_schedul  = 1'b0;
        rng         = 32'ha443baa3;
        tb_errs     = 0;
        errs_before = 0;
        test_num    = 0;
        repeat (8) @(posedge rst);
        clk <= 1'b0;
        register_access();
        report_test("register access");
        single_request();
        report_test("single request");
        need_beats_want();
        report_test("need over want and urgency");
        enable_masking();
        report_test("enable mask");
        window_limit();
        report_test("one grant per window");
        random_traffic();
        report_test("random run");
        $display("summary: %0d tests, %0d compares, %0d errors",
                 test_num, chk_cnt, tb_errs + err_cnt);
        if (tb_errs + err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/sched_checker.sv ====
// sched_checker rebuilds the scheduler state from its ports and compares every grant and read
`timescale 1ns/10ps
`include "sched_defines.svh"

module sched_checker (
    input  logic                      rst,         // clock
    input  logic                      clk,         // async reset, active high
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  sched_bus_pkg::wb_adr_t    wb_adr,
    input  sched_bus_pkg::wb_dat_t    wb_dat_w,
    input  sched_bus_pkg::wb_dat_t    wb_dat_r,
    input  logic                      wb_ack,
    input  sched_chan_pkg::chn_mask_t want_rq,
    input  sched_chan_pkg::chn_mask_t need_rq,
    input  logic                      en_schedul,
    input  logic                      grant,
    input  sched_chan_pkg::chn_idx_t  grant_chn,
    input  logic                      grant_need,
    output int                        err_cnt,     // failed checks
    output int                        chk_cnt      // grants and reads compared
);

    localparam int W = `SCHED_PRI_W;

    sched_chan_pkg::chn_mask_t  m_en;              // enable mask seen on the bus
    sched_chan_pkg::chn_mask_t  m_wconf;           // modelled want confirms
    sched_chan_pkg::chn_mask_t  m_nconf;           // modelled need confirms
    logic [`SCHED_CHN*W-1:0]    m_prio;            // priorities seen on the bus
    logic [`SCHED_CHN*W-1:0]    m_urg;             // modelled urgency counters
    sched_chan_pkg::sel_state_t m_state;
    logic                       m_ack;             // ack due in this cycle
    logic                       exp_pend;          // grant due in this cycle
    sched_chan_pkg::chn_idx_t   exp_chn;
    logic                       exp_need;
    sched_chan_pkg::chn_idx_t   last_chn;          // grant_chn holds between grants

    // two's complement trick isolates the lowest set bit
    function automatic sched_chan_pkg::chn_mask_t lowest_bit(input sched_chan_pkg::chn_mask_t m);
        return m & (~m + sched_chan_pkg::chn_mask_t'(1));
    endfunction

    // winner and class from confirms, enables and urgencies
    function automatic logic expected_grant(
        input  sched_chan_pkg::chn_mask_t wconf,
        input  sched_chan_pkg::chn_mask_t nconf,
        input  sched_chan_pkg::chn_mask_t en,
        input  logic [`SCHED_CHN*W-1:0]   urg,
        output sched_chan_pkg::chn_idx_t  idx,
        output logic                      need
    );
        sched_chan_pkg::chn_mask_t cand;
        sched_chan_pkg::prio_t     best;
        logic                      found;
        need  = |(nconf & en);                     // one enabled need shuts out all wants
        cand  = need ? nconf : wconf;
        found = 1'b0;
        best  = '0;
        idx   = '0;
        for (int i = 0; i < `SCHED_CHN; i++) begin
            // strictly greater, equal urgency stays with the lower channel
            if (cand[i] && (!found || urg[i*W +: W] > best)) begin
                found = 1'b1;
                best  = urg[i*W +: W];
                idx   = sched_chan_pkg::chn_idx_t'(i);
            end
        end
        return found;
    endfunction

    always @(posedge rst or posedge clk) begin
        sched_chan_pkg::chn_mask_t w_acc;
        sched_chan_pkg::chn_mask_t n_acc;
        sched_chan_pkg::chn_idx_t  win;
        logic                      win_need;
        logic                      win_vld;
        sched_bus_pkg::wb_dat_t    rd_exp;
        if (clk) begin
            m_en     = '0;
            m_wconf  = '0;
            m_nconf  = '0;
            m_prio   = '0;
            m_urg    = '0;
            m_state  = sched_chan_pkg::SEL_IDLE;
            m_ack    = 1'b0;
            exp_pend = 1'b0;
            last_chn = '0;
            err_cnt  = 0;
            chk_cnt  = 0;
        end else begin
            // outputs seen here are the values from before this edge
            if (grant && !exp_pend) begin
                $display("unexpected grant on channel %0d at %0d ns", grant_chn, $time);
                err_cnt++;
            end else if (!grant && exp_pend) begin
                $display("grant due at %0d ns did not appear", $time);
                err_cnt++;
            end else if (grant) begin
                chk_cnt++;
                if (grant_chn !== exp_chn || grant_need !== exp_need) begin
                    $display("Mismatch at %0d ns: grant to %0d need %0b, expected %0d need %0b",
                             $time, grant_chn, grant_need, exp_chn, exp_need);
                    err_cnt++;
                end
            end else if (grant_chn !== last_chn) begin
                $display("grant_chn changed without a grant at %0d ns", $time);
                err_cnt++;
            end
            last_chn = grant_chn;
            if (wb_ack !== m_ack) begin
                $display("wishbone ack out of step at %0d ns", $time);
                err_cnt++;
            end
            if (wb_ack && wb_cyc && wb_stb && !wb_we) begin
                rd_exp = '0;                       // unmapped words
                if (wb_adr < `SCHED_CHN) begin
                    rd_exp = sched_bus_pkg::wb_dat_t'(m_prio[wb_adr[3:0]*W +: W]);
                end else if (wb_adr == `SCHED_REG_EN) begin
                    rd_exp = m_en;
                end
                chk_cnt++;
                if (wb_dat_r !== rd_exp) begin
                    $display("Mismatch at %0d ns: read of address %0d gave %h, expected %h",
                             $time, wb_adr, wb_dat_r, rd_exp);
                    err_cnt++;
                end
            end
            // grant machine on the state from before the edge
            exp_pend = 1'b0;
            win_vld  = expected_grant(m_wconf, m_nconf, m_en, m_urg, win, win_need);
            case (m_state)
                sched_chan_pkg::SEL_IDLE: begin
                    if (en_schedul && win_vld) begin
                        exp_pend = 1'b1;
                        exp_chn  = win;
                        exp_need = win_need;
                        m_state  = sched_chan_pkg::SEL_GRANT;
                    end
                end
                sched_chan_pkg::SEL_GRANT: m_state = sched_chan_pkg::SEL_HOLD;
                default: begin
                    if (!en_schedul) begin
                        m_state = sched_chan_pkg::SEL_IDLE;
                    end
                end
            endcase
            // captures, one new request per class and cycle
            w_acc   = lowest_bit(want_rq & m_en & ~m_wconf);
            n_acc   = lowest_bit(need_rq & m_en & ~m_nconf);
            m_wconf = (m_wconf & want_rq & m_en) | w_acc;
            m_nconf = (m_nconf & need_rq & m_en) | n_acc;
            for (int i = 0; i < `SCHED_CHN; i++) begin
                if (w_acc[i] || n_acc[i]) begin
                    m_urg[i*W +: W] = m_prio[i*W +: W];
                end else if (m_urg[i*W +: W] != {W{1'b1}}) begin
                    m_urg[i*W +: W] = m_urg[i*W +: W] + 1'b1; // stops at all ones
                end
            end
            // register writes land last, on the ack edge
            m_ack = wb_cyc & wb_stb & ~wb_ack;
            if (m_ack && wb_we) begin
                if (wb_adr < `SCHED_CHN) begin
                    m_prio[wb_adr[3:0]*W +: W] = wb_dat_w[W-1:0];
                end else if (wb_adr == `SCHED_REG_EN) begin
                    m_en = wb_dat_w;
                end
            end
        end
    end

endmodule

// ==== logic/mem_sched_top.sv ====
// mem_sched_top joins the wishbone priority registers, both request captures and the grant selector
`timescale 1ns/10ps
`include "sched_defines.svh"

module mem_sched_top (
    input  logic                      rst,         // clock
    input  logic                      clk,         // async reset, active high
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  sched_bus_pkg::wb_adr_t    wb_adr,
    input  sched_bus_pkg::wb_dat_t    wb_dat_w,
    output sched_bus_pkg::wb_dat_t    wb_dat_r,
    output logic                      wb_ack,
    input  sched_chan_pkg::chn_mask_t want_rq,     // channel could use the memory
    input  sched_chan_pkg::chn_mask_t need_rq,     // channel must have it soon
    input  logic                      en_schedul,  // opens a scheduling window
    output logic                      grant,
    output sched_chan_pkg::chn_idx_t  grant_chn,
    output logic                      grant_need
);

    sched_chan_pkg::chn_mask_t          chn_en;      // from the register block
    logic [`SCHED_CHN*`SCHED_PRI_W-1:0] prio_table;  // flat priority table
    sched_chan_pkg::chn_mask_t          want_accept;
    sched_chan_pkg::chn_mask_t          want_conf;
    sched_chan_pkg::chn_mask_t          need_accept;
    sched_chan_pkg::chn_mask_t          need_conf;

    prio_regs_wb prio_regs_i (
        .rst        (rst),
        .clk        (clk),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .chn_en     (chn_en),
        .prio_table (prio_table)
    );

    req_capture want_cap_i (
        .rst    (rst),
        .clk    (clk),
        .rq     (want_rq),
        .chn_en (chn_en),
        .accept (want_accept),
        .conf   (want_conf)
    );

    req_capture need_cap_i (
        .rst    (rst),
        .clk    (clk),
        .rq     (need_rq),
        .chn_en (chn_en),
        .accept (need_accept),
        .conf   (need_conf)
    );

    urgency_select select_i (
        .rst         (rst),
        .clk         (clk),
        .chn_en      (chn_en),
        .prio_table  (prio_table),
        .want_accept (want_accept),
        .want_conf   (want_conf),
        .need_accept (need_accept),
        .need_conf   (need_conf),
        .en_schedul  (en_schedul),
        .grant       (grant),
        .grant_chn   (grant_chn),
        .grant_need  (grant_need)
    );

endmodule

// ==== logic/prio_regs_wb.sv ====
// prio_regs_wb holds the channel priorities and the enable mask behind a wishbone classic slave
`timescale 1ns/10ps
`include "sched_defines.svh"

module prio_regs_wb (
    input  logic                               rst,        // clock
    input  logic                               clk,        // async reset, active high
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  sched_bus_pkg::wb_adr_t             wb_adr,     // word address
    input  sched_bus_pkg::wb_dat_t             wb_dat_w,
    output sched_bus_pkg::wb_dat_t             wb_dat_r,   // valid while wb_ack is high
    output logic                               wb_ack,     // one cycle, then one idle cycle
    output sched_chan_pkg::chn_mask_t          chn_en,     // channel enable mask
    output logic [`SCHED_CHN*`SCHED_PRI_W-1:0] prio_table  // channel i at [i*w +: w]
);

    sched_chan_pkg::prio_t  prio_q [`SCHED_CHN];  // one priority per channel
    logic                   acc;                  // access taken on this edge
    logic                   adr_prio;             // address in the priority table
    logic                   adr_en;               // address of the enable mask
    sched_bus_pkg::wb_dat_t rd_mux;               // read data before the register

    // a strobe is only taken while ack is low, so accesses never ack back to back
    assign acc      = wb_cyc & wb_stb & ~wb_ack;
    assign adr_prio = wb_adr < sched_bus_pkg::wb_adr_t'(`SCHED_CHN);
    assign adr_en   = wb_adr == sched_bus_pkg::wb_adr_t'(`SCHED_REG_EN);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= acc;                        // high on the edge after the strobe
        end
    end

    // writes land on the same edge that raises ack
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < `SCHED_CHN; i++) begin
                prio_q[i] <= '0;
            end
            chn_en <= '0;                         // all channels off after reset
        end else if (acc && wb_we) begin
            if (adr_prio) begin
                prio_q[wb_adr[3:0]] <= sched_chan_pkg::prio_t'(wb_dat_w); // low bits kept
            end
            if (adr_en) begin
                chn_en <= wb_dat_w;
            end
        end
    end

    always_comb begin
        rd_mux = '0;                              // unmapped words read zero
        if (adr_prio) begin
            rd_mux = sched_bus_pkg::wb_dat_t'(prio_q[wb_adr[3:0]]); // zero extended
        end else if (adr_en) begin
            rd_mux = chn_en;
        end
    end

    // read data follows the ack, so it is only loaded on a taken access
    always_ff @(posedge rst) begin
        if (acc) begin
            wb_dat_r <= rd_mux;
        end
    end

    // flat priority vector for the selector
    always_comb begin
        for (int i = 0; i < `SCHED_CHN; i++) begin
            prio_table[i*`SCHED_PRI_W +: `SCHED_PRI_W] = prio_q[i];
        end
    end

endmodule

// ==== logic/req_capture.sv ====
// req_capture takes one new request per cycle for a single request class and keeps them confirmed
`timescale 1ns/10ps

module req_capture (
    input  logic                      rst,     // clock
    input  logic                      clk,     // async reset, active high
    input  sched_chan_pkg::chn_mask_t rq,      // raw request levels of this class
    input  sched_chan_pkg::chn_mask_t chn_en,  // channel enable mask
    output sched_chan_pkg::chn_mask_t accept,  // one-hot, high in the cycle a request is taken
    output sched_chan_pkg::chn_mask_t conf     // confirmed requests
);

    sched_chan_pkg::chn_mask_t elig;           // raised, enabled, not yet confirmed
    sched_chan_pkg::chn_mask_t keep;           // confirmed bits that stay after this edge

    assign elig = rq & chn_en & ~conf;
    assign keep = conf & rq & chn_en;          // falls one edge after request or enable

    // lowest eligible index wins
    always_comb begin
        logic found;
        found  = 1'b0;
        accept = '0;
        for (int i = 0; i < $bits(elig); i++) begin
            if (elig[i] && !found) begin
                accept[i] = 1'b1;              // first hit scanning upward
                found     = 1'b1;
            end
        end
    end

    // an accepted bit shows up in conf on the next edge
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            conf <= '0;
        end else begin
            conf <= keep | accept;
        end
    end

endmodule

// ==== logic/sched_bus_pkg.sv ====
// sched_bus_pkg collects the wishbone programming bus types of the scheduler

package sched_bus_pkg;

    // word address, 32 words of which 17 are mapped
    typedef logic [4:0] wb_adr_t;

    // data word, wide enough for the full enable mask
    typedef logic [15:0] wb_dat_t;

endpackage

// ==== logic/sched_chan_pkg.sv ====
// sched_chan_pkg collects the channel-side types of the memory access scheduler
`include "sched_defines.svh"

package sched_chan_pkg;

    // one bit per channel, used for requests, enables, accepts and confirms
    typedef logic [`SCHED_CHN-1:0] chn_mask_t;

    // channel number, 16 channels
    typedef logic [3:0] chn_idx_t;

    // programmed priority and aging urgency share one width
    typedef logic [`SCHED_PRI_W-1:0] prio_t;

    // grant machine, one grant per scheduling window
    typedef enum logic [1:0] {
        SEL_IDLE  = 2'd0,   // waiting for en_schedul and a candidate
        SEL_GRANT = 2'd1,   // grant pulse is out
        SEL_HOLD  = 2'd2    // window used up, wait for en_schedul low
    } sel_state_t;

endpackage

// ==== logic/sched_defines.svh ====
// sched defines hold the channel count, priority width and wishbone register map of the scheduler
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// channel count, fixed for the 4-bit channel index
`define SCHED_CHN 16

// priority and urgency counter width, anything from 4 to 16 works
`define SCHED_PRI_W 8

// wishbone word addresses
// 0 to 15 hold one priority each
// 16 holds the enable mask
// 17 to 31 are unmapped and read zero
`define SCHED_REG_EN 16

`endif

// ==== logic/urgency_select.sv ====
// urgency_select ages channel urgencies and grants the most urgent confirmed channel, need before want
`timescale 1ns/10ps
`include "sched_defines.svh"

module urgency_select (
    input  logic                               rst,          // clock
    input  logic                               clk,          // async reset, active high
    input  sched_chan_pkg::chn_mask_t          chn_en,       // channel enable mask
    input  logic [`SCHED_CHN*`SCHED_PRI_W-1:0] prio_table,   // channel i at [i*w +: w]
    input  sched_chan_pkg::chn_mask_t          want_accept,  // one-hot want acceptance
    input  sched_chan_pkg::chn_mask_t          want_conf,    // confirmed want requests
    input  sched_chan_pkg::chn_mask_t          need_accept,  // one-hot need acceptance
    input  sched_chan_pkg::chn_mask_t          need_conf,    // confirmed need requests
    input  logic                               en_schedul,   // scheduling window
    output logic                               grant,        // single-cycle grant pulse
    output sched_chan_pkg::chn_idx_t           grant_chn,    // held until the next grant
    output logic                               grant_need    // granted as needed, not wanted
);

    localparam int NODES = 2*`SCHED_CHN - 1;   // heap layout, leaf of channel i at CHN-1+i

    sched_chan_pkg::prio_t      urg [`SCHED_CHN];       // urgency counters
    sched_chan_pkg::chn_mask_t  load;                   // reload from priority this edge
    logic                       need_any;               // some enabled need is confirmed
    sched_chan_pkg::chn_mask_t  cand;                   // channels taking part in the search
    sched_chan_pkg::prio_t      node_val [NODES];       // best urgency below each node
    sched_chan_pkg::chn_idx_t   node_idx [NODES];       // channel holding it
    logic                       node_vld [NODES];       // any candidate below the node
    logic                       win_vld;
    sched_chan_pkg::chn_idx_t   win_idx;
    sched_chan_pkg::sel_state_t state;

    assign load     = want_accept | need_accept;        // either class restarts aging
    assign need_any = |(need_conf & chn_en);
    assign cand     = need_any ? need_conf : want_conf; // needed channels shut out wanted ones

    // load on acceptance, otherwise age up to all ones
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < `SCHED_CHN; i++) begin
                urg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SCHED_CHN; i++) begin
                if (load[i]) begin
                    urg[i] <= prio_table[i*`SCHED_PRI_W +: `SCHED_PRI_W];
                end else if (~&urg[i]) begin
                    urg[i] <= urg[i] + sched_chan_pkg::prio_t'(1); // saturates, no wrap
                end
            end
        end
    end

    // maximum search tree, parents built bottom up from the leaves
    always_comb begin
        logic take_r;
        take_r = 1'b0;
        for (int i = 0; i < `SCHED_CHN; i++) begin
            node_val[`SCHED_CHN-1+i] = urg[i];
            node_idx[`SCHED_CHN-1+i] = sched_chan_pkg::chn_idx_t'(i);
            node_vld[`SCHED_CHN-1+i] = cand[i];
        end
        for (int k = `SCHED_CHN-2; k >= 0; k--) begin
            // right side only on strictly greater, ties keep the lower index on the left
            take_r = node_vld[2*k+2] &&
                     (!node_vld[2*k+1] || (node_val[2*k+2] > node_val[2*k+1]));
            node_val[k] = take_r ? node_val[2*k+2] : node_val[2*k+1];
            node_idx[k] = take_r ? node_idx[2*k+2] : node_idx[2*k+1];
            node_vld[k] = node_vld[2*k+1] | node_vld[2*k+2];
        end
    end

    assign win_vld = node_vld[0];                       // root of the tree
    assign win_idx = node_idx[0];

    // one grant per window, en_schedul low reopens it
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state      <= sched_chan_pkg::SEL_IDLE;
            grant      <= 1'b0;
            grant_chn  <= '0;
            grant_need <= 1'b0;
        end else begin
            grant <= 1'b0;                              // pulse by default off
            case (state)
                sched_chan_pkg::SEL_IDLE: begin
                    if (en_schedul && win_vld) begin
                        grant      <= 1'b1;
                        grant_chn  <= win_idx;          // latched with the pulse
                        grant_need <= need_any;         // class of the winner
                        state      <= sched_chan_pkg::SEL_GRANT;
                    end
                end
                sched_chan_pkg::SEL_GRANT: begin
                    state <= sched_chan_pkg::SEL_HOLD;  // pulse lasts one cycle
                end
                sched_chan_pkg::SEL_HOLD: begin
                    if (!en_schedul) begin
                        state <= sched_chan_pkg::SEL_IDLE;
                    end
                end
                default: begin
                    state <= sched_chan_pkg::SEL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/sched_chan_pkg.sv
logic/sched_bus_pkg.sv
logic/prio_regs_wb.sv
logic/req_capture.sv
logic/urgency_select.sv
logic/mem_sched_top.sv
dv/sched_checker.sv
dv/mem_sched_tb.sv
